// File: Makefile
# Verilator build and run of the ROM fetch hub testbench

TOP = rom_hub_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f src.f
	@out="$$(./obj_dir/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir

// File: design/rom_arbiter.sv
/* Fixed-priority read arbiter for the shared SDRAM port
   Slot 0 wins; reads go out only while the memory has credits left */

`timescale 1ns/1ps

module rom_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    // Slot requests
    input  logic [rom_pkg::num_slots-1:0] req,
    input  rom_pkg::sdram_addr_t          req_addr [rom_pkg::num_slots],
    output logic [rom_pkg::num_slots-1:0] grant,
    // SDRAM read port
    output logic                          sdram_req,
    output rom_pkg::sdram_addr_t          sdram_addr,
    output rom_pkg::slot_tag_t            sdram_tag,
    input  logic                          sdram_credit
);

    typedef logic [$clog2(rom_pkg::mem_credits + 1) - 1:0] credit_t;

    credit_t credits;                  // Free read slots at the memory
    logic    credit_avail;

    assign credit_avail = (credits != '0);

    // Lowest index wins, later loop passes override higher ones
    always_comb begin
        grant      = '0;
        sdram_addr = '0;
        sdram_tag  = '0;
        if (credit_avail) begin
            for (int i = rom_pkg::num_slots - 1; i >= 0; i--) begin
                if (req[i]) begin
                    grant      = '0;
                    grant[i]   = 1'b1;
                    sdram_addr = req_addr[i];
                    sdram_tag  = rom_pkg::slot_tag_t'(i);
                end
            end
        end
        sdram_req = |grant;            // One issue per cycle at most
    end

    // Credit counter
    // An issue and a returned credit in the same cycle cancel out
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= credit_t'(rom_pkg::mem_credits);
        end else begin
            case ({sdram_req, sdram_credit})
                2'b10: begin
                    credits <= credits - 1'b1;
                end
                2'b01: begin
                    if (credits != credit_t'(rom_pkg::mem_credits)) begin
                        credits <= credits + 1'b1;   // Saturates at full
                    end
                end
                default: begin
                    credits <= credits;
                end
            endcase
        end
    end

endmodule

// File: design/rom_hub.sv
/* Multi-slot ROM fetch hub
   Client slots share one credit-controlled SDRAM read port */

`timescale 1ns/1ps

module rom_hub (
    input  logic                          clk,
    input  logic                          rst,
    // Clients
    input  logic [rom_pkg::num_slots-1:0] slot_cs,
    input  rom_pkg::slot_addr_t           slot_addr [rom_pkg::num_slots],
    output logic [rom_pkg::num_slots-1:0] slot_ok,
    output rom_pkg::rom_word_t            slot_dout [rom_pkg::num_slots],
    // SDRAM read port
    output logic                          sdram_req,
    output rom_pkg::sdram_addr_t          sdram_addr,
    output rom_pkg::slot_tag_t            sdram_tag,
    input  logic                          sdram_credit,
    input  logic                          data_rdy,
    input  rom_pkg::slot_tag_t            data_tag,
    input  rom_pkg::rom_word_t            data_read
);

    logic [rom_pkg::num_slots-1:0] req;
    logic [rom_pkg::num_slots-1:0] grant;
    logic [rom_pkg::num_slots-1:0] resp_valid;
    rom_pkg::sdram_addr_t          req_addr [rom_pkg::num_slots];
    rom_pkg::rom_word_t            resp_data;

    rom_arbiter u_arb (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .req          ( req          ),
        .req_addr     ( req_addr     ),
        .grant        ( grant        ),
        .sdram_req    ( sdram_req    ),
        .sdram_addr   ( sdram_addr   ),
        .sdram_tag    ( sdram_tag    ),
        .sdram_credit ( sdram_credit )
    );

    // One slot per client, each with its own ROM base
    for (genvar i = 0; i < rom_pkg::num_slots; i++) begin : g_slot
        rom_slot #(
            .offset ( rom_pkg::slot_offset[i] )
        ) u_slot (
            .clk        ( clk           ),
            .rst        ( rst           ),
            .cs         ( slot_cs[i]    ),
            .addr       ( slot_addr[i]  ),
            .ok         ( slot_ok[i]    ),
            .dout       ( slot_dout[i]  ),
            .req        ( req[i]        ),
            .req_addr   ( req_addr[i]   ),
            .grant      ( grant[i]      ),
            .resp_valid ( resp_valid[i] ),
            .resp_data  ( resp_data     )
        );
    end

    rom_resp_router u_router (
        .data_rdy   ( data_rdy   ),
        .data_tag   ( data_tag   ),
        .data_read  ( data_read  ),
        .resp_valid ( resp_valid ),
        .resp_data  ( resp_data  )
    );

endmodule

// File: design/rom_pkg.sv
/* ROM fetch hub shared definitions
   Slot count, bus widths, memory credits and per-slot SDRAM base addresses */

package rom_pkg;

    // Client side
    localparam int num_slots = 5;
    localparam int slot_aw   = 15;     // Word address seen by a client

    // SDRAM side
    localparam int sdram_aw    = 22;
    localparam int data_w      = 16;
    localparam int mem_credits = 2;    // Reads the memory can hold at once

    // Enough bits to name any slot
    localparam int tag_w = 3;

    typedef logic [slot_aw-1:0]  slot_addr_t;
    typedef logic [sdram_aw-1:0] sdram_addr_t;
    typedef logic [data_w-1:0]   rom_word_t;
    typedef logic [tag_w-1:0]    slot_tag_t;

    // SDRAM word base of each client's ROM region
    // 0 char, 1 scroll, 2 sound, 3 main CPU, 4 objects
    localparam sdram_addr_t slot_offset [num_slots] = '{
        22'h00000,
        22'h0A000,
        22'h10000,
        22'h14000,
        22'h20000
    };

endpackage

// File: design/rom_resp_router.sv
/* Response router
   Turns the returned tag into a one-hot valid toward the slots */

`timescale 1ns/1ps

module rom_resp_router (
    input  logic                          data_rdy,
    input  rom_pkg::slot_tag_t            data_tag,
    input  rom_pkg::rom_word_t            data_read,
    output logic [rom_pkg::num_slots-1:0] resp_valid,
    output rom_pkg::rom_word_t            resp_data
);

    // Tags past the last slot match no index and go nowhere
    always_comb begin
        resp_valid = '0;
        if (data_rdy) begin
            for (int i = 0; i < rom_pkg::num_slots; i++) begin
                resp_valid[i] = (data_tag == rom_pkg::slot_tag_t'(i));
            end
        end
    end

    // Every slot sees the word, only the tagged one latches it
    assign resp_data = data_read;

endmodule

// File: design/rom_slot.sv
/* ROM client slot
   Offsets the client address, caches one word and fetches on a miss */

`timescale 1ns/1ps

module rom_slot #(
    parameter rom_pkg::sdram_addr_t offset = '0
)(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cs,
    input  rom_pkg::slot_addr_t  addr,
    output logic                 ok,
    output rom_pkg::rom_word_t   dout,
    // Toward the arbiter
    output logic                 req,
    output rom_pkg::sdram_addr_t req_addr,
    input  logic                 grant,
    // From the response router
    input  logic                 resp_valid,
    input  rom_pkg::rom_word_t   resp_data
);

    rom_pkg::sdram_addr_t full_addr;
    rom_pkg::sdram_addr_t cached_addr;
    rom_pkg::sdram_addr_t pend_addr;   // Address of the read in flight
    logic                 cache_valid;
    logic                 pending;
    logic                 hit;

    assign full_addr = offset + rom_pkg::sdram_addr_t'(addr);
    assign hit       = cache_valid && (cached_addr == full_addr);
    assign ok        = hit;            // Same cycle as the address match
    assign req_addr  = full_addr;

    // Request and pending tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            req     <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (req) begin
                if (grant) begin
                    req     <= 1'b0;
                    pending <= 1'b1;
                end
            end else if (cs && !hit && !pending) begin
                req <= 1'b1;           // Miss, fetch next cycle
            end
            if (resp_valid) pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cache_valid <= 1'b0;
        end else if (resp_valid) begin
            cache_valid <= 1'b1;
        end
    end

    // Payload side
    always_ff @(posedge clk) begin
        if (req && grant) pend_addr <= full_addr;
        if (resp_valid) begin
            cached_addr <= pend_addr;  // Word belongs to the granted address
            dout        <= resp_data;
        end
    end

endmodule

// File: src.f
design/rom_pkg.sv
design/rom_slot.sv
design/rom_arbiter.sv
design/rom_resp_router.sv
design/rom_hub.sv
verif/sdram_model.sv
verif/rom_hub_assertions.sv
verif/rom_hub_tb.sv

// File: verif/rom_hub_assertions.sv
/* Arbiter protocol checks
   Credit return and slot request handshake at the SDRAM arbiter */

`timescale 1ns/1ps

module rom_hub_assertions (
    input logic                                          clk,
    input logic                                          rst,
    input logic [$clog2(rom_pkg::mem_credits + 1) - 1:0] credits,
    input logic [rom_pkg::num_slots-1:0]                 req,
    input logic [rom_pkg::num_slots-1:0]                 grant,
    input logic                                          sdram_credit
);

    logic fail_seen = 1'b0;    // Sticky, read by the testbench at the end

    // A credit back while the counter is full has no read to belong to
    credit_bound: assert property (@(posedge clk) disable iff (rst)
        sdram_credit |-> credits != rom_pkg::mem_credits)
        else begin
            fail_seen = 1'b1;
            $error("credit returned with the counter already full");
        end

    for (genvar i = 0; i < rom_pkg::num_slots; i++) begin : g_slot
        // Waiting slots keep asking
        req_held: assert property (@(posedge clk) disable iff (rst)
            req[i] && !grant[i] |=> req[i])
            else begin
                fail_seen = 1'b1;
                $error("slot %0d dropped req before its grant", i);
            end

        req_drop: assert property (@(posedge clk) disable iff (rst)
            grant[i] |=> !req[i])
            else begin
                fail_seen = 1'b1;
                $error("slot %0d kept req after its grant", i);
            end
    end

endmodule

bind rom_arbiter rom_hub_assertions u_checks (
    .clk          ( clk          ),
    .rst          ( rst          ),
    .credits      ( credits      ),
    .req          ( req          ),
    .grant        ( grant        ),
    .sdram_credit ( sdram_credit )
);

// File: verif/rom_hub_tb.sv
/* ROM fetch hub testbench
   Directed tests of slot reads, caching, priority and credit flow */

`timescale 1ns/1ps

module rom_hub_tb;

    localparam int max_cycles = 2000;   // Six tests, none longer than ~200 cycles

    // SDRAM base of each slot's region
    localparam logic [21:0] rom_base [5] = '{
        22'h00000, 22'h0A000, 22'h10000, 22'h14000, 22'h20000
    };

    logic                          clk;
    logic                          rst;
    logic [rom_pkg::num_slots-1:0] slot_cs;
    rom_pkg::slot_addr_t           slot_addr [rom_pkg::num_slots];
    logic [rom_pkg::num_slots-1:0] slot_ok;
    rom_pkg::rom_word_t            slot_dout [rom_pkg::num_slots];
    logic                          sdram_req;
    rom_pkg::sdram_addr_t          sdram_addr;
    rom_pkg::slot_tag_t            sdram_tag;
    logic                          sdram_credit;
    logic                          data_rdy;
    rom_pkg::slot_tag_t            data_tag;
    rom_pkg::rom_word_t            data_read;
    logic                          hold_credits;

    logic [31:0]                   seed = 32'h193e;
    int                            cycle_count = 0;
    int                            req_count = 0;   // sdram_req pulses seen
    rom_pkg::slot_tag_t            tag_log [$];     // Tags in issue order
    rom_pkg::sdram_addr_t          addr_log [$];    // Addresses in issue order

    rom_hub rom_hub_i (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .slot_cs      ( slot_cs      ),
        .slot_addr    ( slot_addr    ),
        .slot_ok      ( slot_ok      ),
        .slot_dout    ( slot_dout    ),
        .sdram_req    ( sdram_req    ),
        .sdram_addr   ( sdram_addr   ),
        .sdram_tag    ( sdram_tag    ),
        .sdram_credit ( sdram_credit ),
        .data_rdy     ( data_rdy     ),
        .data_tag     ( data_tag     ),
        .data_read    ( data_read    )
    );

    sdram_model sdram_model_i (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .sdram_req    ( sdram_req    ),
        .sdram_addr   ( sdram_addr   ),
        .sdram_tag    ( sdram_tag    ),
        .hold_credits ( hold_credits ),
        .sdram_credit ( sdram_credit ),
        .data_rdy     ( data_rdy     ),
        .data_tag     ( data_tag     ),
        .data_read    ( data_read    )
    );

    always #10 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    // Read monitor and timeout
    always @(posedge clk) begin
        cycle_count++;
        if (!rst && sdram_req) begin
            req_count++;
            tag_log.push_back(sdram_tag);
            addr_log.push_back(sdram_addr);
        end
        if (cycle_count >= max_cycles) begin
            stop_on_error($sformatf("timeout: run went past %0d cycles", max_cycles));
        end
    end

    task automatic check(input string test, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            stop_on_error($sformatf("error %s: expected %0h, actual %0h",
                                    test, expected, actual));
        end
    endtask

    function automatic rom_pkg::slot_addr_t rand_addr();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[30:16];
    endfunction

    // SDRAM word address behind a client address
    function automatic logic [21:0] sdram_word_addr(input int s, input logic [14:0] a);
        return rom_base[s] + {7'd0, a};
    endfunction

    // ROM content: low half of the SDRAM word address, scrambled
    function automatic logic [15:0] expected_word(input int s, input logic [14:0] a);
        logic [21:0] word_addr;
        word_addr = sdram_word_addr(s, a);
        return word_addr[15:0] ^ 16'h5A5A;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_ok(input int s, input string test);
        int n;
        n = 0;
        tick();
        while (!slot_ok[s]) begin
            tick();
            n++;
            if (n > 200) begin
                stop_on_error($sformatf("%s: slot %0d never raised ok", test, s));
            end
        end
    endtask

    task automatic test_reset();
        tick();
        check("reset slot_ok", 0, slot_ok);
        check("reset sdram_req", 0, sdram_req);
    endtask

    task automatic test_single_read();
        slot_addr[1] = 15'h0123;
        slot_cs[1]   = 1'b1;
        wait_ok(1, "single_read");
        check("single_read data", expected_word(1, 15'h0123), slot_dout[1]);
    endtask

    task automatic test_cache_hit();
        int start;
        start        = req_count;
        slot_addr[1] = 15'h0123;        // Same address again
        for (int i = 0; i < 10; i++) begin
            tick();
            check("cache_hit ok", 1, slot_ok[1]);
        end
        check("cache_hit reads", 0, req_count - start);
        check("cache_hit data", expected_word(1, 15'h0123), slot_dout[1]);
    endtask

    task automatic test_all_slots();
        int                  start;
        rom_pkg::slot_addr_t a [rom_pkg::num_slots];
        tag_log.delete();
        addr_log.delete();
        start = req_count;
        for (int s = 0; s < rom_pkg::num_slots; s++) begin
            a[s]         = rand_addr();
            slot_addr[s] = a[s];
        end
        slot_cs = '1;
        for (int s = 0; s < rom_pkg::num_slots; s++) begin
            wait_ok(s, "all_slots");
            check("all_slots data", expected_word(s, a[s]), slot_dout[s]);
        end
        check("all_slots reads", rom_pkg::num_slots, req_count - start);
        // All asked together, so slot 0 goes first and slot 4 last
        for (int i = 0; i < rom_pkg::num_slots; i++) begin
            check("all_slots tag order", i, tag_log[i]);
            check("all_slots address", sdram_word_addr(i, a[i]), addr_log[i]);
        end
    endtask

    task automatic test_credit_hold();
        int                  start;
        rom_pkg::slot_addr_t a [rom_pkg::num_slots];
        start        = req_count;
        hold_credits = 1'b1;
        for (int s = 0; s < rom_pkg::num_slots; s++) begin
            a[s]         = rand_addr();
            slot_addr[s] = a[s];
        end
        repeat (20) tick();
        check("credit_hold reads", rom_pkg::mem_credits, req_count - start);
        check("credit_hold slot_ok", 0, slot_ok);
        hold_credits = 1'b0;
        for (int s = 0; s < rom_pkg::num_slots; s++) begin
            wait_ok(s, "credit_hold");
            check("credit_hold data", expected_word(s, a[s]), slot_dout[s]);
        end
    endtask

    task automatic test_addr_change();
        int start;
        int n;
        start        = req_count;
        n            = 0;
        slot_addr[3] = 15'h1000;
        while (req_count == start) begin
            tick();
            n++;
            if (n > 50) begin
                stop_on_error("addr_change: read for slot 3 was never issued");
            end
        end
        slot_addr[3] = 15'h1001;        // Move before the word comes back
        wait_ok(3, "addr_change");
        check("addr_change data", expected_word(3, 15'h1001), slot_dout[3]);
        check("addr_change reads", 2, req_count - start);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        slot_cs      = '0;
        hold_credits = 1'b0;
        for (int s = 0; s < rom_pkg::num_slots; s++) begin
            slot_addr[s] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset();
        test_single_read();
        test_cache_hit();
        test_all_slots();
        test_credit_hold();
        test_addr_change();

        if (rom_hub_i.u_arb.u_checks.fail_seen) begin
            $display("an arbiter assertion failed during the run");
            $display("TEST FAILED");
            $fatal(1, "assertion failure");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// File: verif/sdram_model.sv
/* Behavioural SDRAM read port
   Fixed-latency, in-order reads; a credit goes back with every returned word */

`timescale 1ns/1ps

module sdram_model (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sdram_req,
    input  rom_pkg::sdram_addr_t sdram_addr,
    input  rom_pkg::slot_tag_t   sdram_tag,
    input  logic                 hold_credits,   // Stalls responses and credits
    output logic                 sdram_credit,
    output logic                 data_rdy,
    output rom_pkg::slot_tag_t   data_tag,
    output rom_pkg::rom_word_t   data_read
);

    localparam int latency = 4;

    rom_pkg::sdram_addr_t addr_q [$];
    rom_pkg::slot_tag_t   tag_q [$];
    int                   due_q [$];       // Cycle at which each read is done
    int                   cycle;

    assign sdram_credit = data_rdy;

    initial begin
        data_rdy  = 1'b0;
        data_tag  = '0;
        data_read = '0;
        cycle     = 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            cycle     <= 0;
            data_rdy  <= 1'b0;
            data_tag  <= '0;
            data_read <= '0;
            addr_q.delete();
            tag_q.delete();
            due_q.delete();
        end else begin
            cycle    <= cycle + 1;
            data_rdy <= 1'b0;
            if (sdram_req) begin
                addr_q.push_back(sdram_addr);
                tag_q.push_back(sdram_tag);
                due_q.push_back(cycle + latency);
            end
            // Oldest finished read goes out first
            if (!hold_credits && due_q.size() != 0 && due_q[0] <= cycle) begin
                data_rdy  <= 1'b1;
                data_tag  <= tag_q[0];
                data_read <= rom_pkg::rom_word_t'(addr_q[0]) ^ 16'h5A5A;
                addr_q.delete(0);
                tag_q.delete(0);
                due_q.delete(0);
            end
        end
    end

endmodule
